// ==== verilog.f ====
mce_pkg.sv
seed_if.sv
seed_loader.sv
seed_store.sv
shake_feeder.sv
support_collector.sv
support_gen_top.sv
support_gen_properties.sv
tb_support_gen.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_support_gen
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_support_gen.sv ====
`timescale 1ns/10ps

module tb_support_gen;
    import mce_pkg::*;

    parameter param_set_e PARAM_SET = param_set_1;
    localparam int MSG_WORDS = 11;

    function automatic int ref_s_words(param_set_e ps);
        case (ps)
            param_set_1: return 109;
            param_set_2: return 144;
            param_set_3: return 209;
            default:     return 256;
        endcase
    endfunction

    function automatic word_t ref_fblock(param_set_e ps);
        case (ps)
            param_set_1: return 32'h40020DA0;
            param_set_2: return 32'h40041200;
            param_set_3: return 32'h40041A20;
            default:     return 32'h40042000;
        endcase
    endfunction

    localparam int S_WORDS = ref_s_words(PARAM_SET);
    // 2^M alpha words where M is 12 only for set 1
    localparam int A_WORDS = (PARAM_SET == param_set_1) ? 4096 : 8192;
    localparam int RUN_WORDS = S_WORDS + A_WORDS;

    logic                    clk;
    logic                    rst;
    logic                    delta_valid;
    word_t                   delta;
    logic                    delta_ready;
    logic                    shake_din_valid;
    word_t                   shake_din;
    logic                    shake_din_ready;
    logic                    shake_dout_valid;
    word_t                   shake_dout;
    logic                    shake_dout_ready;
    logic                    s_wr_en;
    logic [7:0]              s_wr_addr;
    word_t                   s_data;
    logic                    alpha_wr_en;
    logic [ALPHA_ADDR_W-1:0] alpha_wr_addr;
    word_t                   alpha_data;
    logic                    done;

    // delta words of the current run and SHAKE output words of both runs
    word_t delta_words [8];
    word_t dout_words [2*RUN_WORDS];
    word_t data_rng;
    int    run_no = 0;
    int    run_base = 0;
    int    dout_limit = 0;
    int    dout_sent = 0;
    int    msg_idx = 0;
    int    s_idx = 0;
    int    a_idx = 0;
    logic  din_pending = 1'b0;
    word_t din_held;

    support_gen_top #(.PARAM_SET(PARAM_SET)) i_support_gen_top (
        .clk              (clk),
        .rst              (rst),
        .delta_valid      (delta_valid),
        .delta            (delta),
        .delta_ready      (delta_ready),
        .shake_din_valid  (shake_din_valid),
        .shake_din        (shake_din),
        .shake_din_ready  (shake_din_ready),
        .shake_dout_valid (shake_dout_valid),
        .shake_dout       (shake_dout),
        .shake_dout_ready (shake_dout_ready),
        .s_wr_en          (s_wr_en),
        .s_wr_addr        (s_wr_addr),
        .s_data           (s_data),
        .alpha_wr_en      (alpha_wr_en),
        .alpha_wr_addr    (alpha_wr_addr),
        .alpha_data       (alpha_data),
        .done             (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic word_t lcg_next(word_t x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t bit_reverse(word_t w);
        return {<<{w}};
    endfunction

    // expected SHAKE input word idx of the current seed
    function automatic word_t ref_msg_word(int idx);
        word_t cur;
        word_t prev;
        if (idx == 0) begin
            return ref_fblock(PARAM_SET);
        end
        if (idx == 1) begin
            return 32'h80000108;
        end
        cur  = (idx < 10) ? bit_reverse(delta_words[idx-2]) : 32'h0;
        // the appended 0x40 byte leads the seed
        prev = (idx > 2) ? bit_reverse(delta_words[idx-3]) : 32'h40000000;
        return {cur[23:0], prev[31:24]};
    endfunction

    task automatic report_failure(string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_msg(string name, word_t exp, word_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_s(string name, logic [7:0] exp_addr, logic [7:0] act_addr,
                           word_t exp_data, word_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            report_failure($sformatf("** Error: %s expected %0d/%h actual %0d/%h",
                                     name, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic check_alpha(string name, logic [ALPHA_ADDR_W-1:0] exp_addr,
                               logic [ALPHA_ADDR_W-1:0] act_addr,
                               word_t exp_data, word_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            report_failure($sformatf("** Error: %s expected %0d/%h actual %0d/%h",
                                     name, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            report_failure($sformatf("** Error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // SHAKE core input side ready about three clocks in four
    initial begin : shake_in_model
        word_t rng;
        rng = 32'd73 ^ 32'h9e3779b9;
        shake_din_ready = 1'b0;
        forever begin
            @(negedge clk);
            rng = lcg_next(rng);
            shake_din_ready = (rng[31:30] != 2'b00);
        end
    end

    // SHAKE core output side holds a word until it is taken
    initial begin : shake_out_model
        word_t rng;
        logic  taken;
        rng = 32'd73 ^ 32'h7f4a7c15;
        shake_dout_valid = 1'b0;
        shake_dout = '0;
        forever begin
            @(posedge clk);
            taken = shake_dout_valid && shake_dout_ready;
            @(negedge clk);
            if (taken) begin
                dout_sent++;
            end
            if (taken || !shake_dout_valid) begin
                rng = lcg_next(rng);
                if (dout_sent < dout_limit && rng[31:30] != 2'b00) begin
                    shake_dout_valid = 1'b1;
                    shake_dout = dout_words[dout_sent];
                end else begin
                    shake_dout_valid = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (din_pending && (!shake_din_valid || shake_din !== din_held)) begin
                report_failure("SHAKE input word withdrawn or changed before it was taken");
            end
            din_pending = shake_din_valid && !shake_din_ready;
            din_held = shake_din;
            if (s_wr_en && alpha_wr_en) begin
                report_failure("s and alpha write enables were high in the same cycle");
            end
            if (shake_dout_ready && msg_idx != MSG_WORDS) begin
                report_failure("shake_dout_ready rose before the message was sent");
            end
            if (shake_din_valid && shake_din_ready) begin
                if (msg_idx >= MSG_WORDS) begin
                    report_failure("feeder sent a word after the closing word");
                end
                check_msg($sformatf("run %0d msg word %0d", run_no, msg_idx),
                          ref_msg_word(msg_idx), shake_din);
                msg_idx++;
            end
            if (s_wr_en) begin
                check_s($sformatf("run %0d s write %0d", run_no, s_idx), s_idx[7:0], s_wr_addr,
                        dout_words[run_base + s_idx], s_data);
                s_idx++;
            end
            if (alpha_wr_en) begin
                check_alpha($sformatf("run %0d alpha write %0d", run_no, a_idx),
                            a_idx[ALPHA_ADDR_W-1:0], alpha_wr_addr,
                            bit_reverse(dout_words[run_base + S_WORDS + a_idx]), alpha_data);
                a_idx++;
            end
            if (done) begin
                check_count($sformatf("run %0d message words", run_no), MSG_WORDS, msg_idx);
                check_count($sformatf("run %0d s writes", run_no), S_WORDS, s_idx);
                check_count($sformatf("run %0d alpha writes", run_no), A_WORDS, a_idx);
                msg_idx = 0;
                s_idx = 0;
                a_idx = 0;
            end
        end
    end

    task automatic run_support(int run);
        int wait_cnt;
        run_no = run;
        for (int k = 0; k < 8; k++) begin
            data_rng = lcg_next(data_rng);
            delta_words[k] = data_rng;
        end
        for (int i = 0; i < RUN_WORDS; i++) begin
            data_rng = lcg_next(data_rng);
            dout_words[run_base + i] = data_rng;
        end
        dout_limit = run_base + RUN_WORDS;
        for (int k = 0; k < 8; k++) begin
            delta_valid = 1'b1;
            delta = delta_words[k];
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
                if (wait_cnt > 100) begin
                    report_failure("timeout waiting for delta_ready");
                end
            end while (!delta_ready);
            @(negedge clk);
        end
        delta_valid = 1'b0;
        check_flag($sformatf("run %0d delta_ready after seed", run), 1'b0, delta_ready);
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 8 * RUN_WORDS + 1000) begin
                report_failure("timeout waiting for done");
            end
        end while (!done);
        @(negedge clk);
        check_flag($sformatf("run %0d done pulse length", run), 1'b0, done);
        check_flag($sformatf("run %0d delta_ready after done", run), 1'b1, delta_ready);
        check_flag($sformatf("run %0d shake_dout_ready after done", run), 1'b0,
                   shake_dout_ready);
        check_count($sformatf("run %0d SHAKE output words taken", run), dout_limit, dout_sent);
        run_base = run_base + RUN_WORDS;
    endtask

    initial begin : main_seq
        rst = 1'b1;
        delta_valid = 1'b0;
        delta = '0;
        data_rng = 32'd73;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_flag("reset delta_ready", 1'b1, delta_ready);
        check_flag("reset shake_din_valid", 1'b0, shake_din_valid);
        check_flag("reset shake_dout_ready", 1'b0, shake_dout_ready);
        check_flag("reset s_wr_en", 1'b0, s_wr_en);
        check_flag("reset alpha_wr_en", 1'b0, alpha_wr_en);
        check_flag("reset done", 1'b0, done);
        run_support(1);
        // second seed right after done
        run_support(2);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== support_gen_properties.sv ====
`timescale 1ns/10ps

module support_gen_properties (
    input logic           clk,
    input logic           rst,
    input logic           shake_din_valid,
    input mce_pkg::word_t shake_din,
    input logic           shake_din_ready,
    input logic           s_wr_en,
    input logic           alpha_wr_en,
    input logic           done
);

    // an offered word stays on the bus until it is taken
    din_held: assert property (
        @(posedge clk) disable iff (rst)
        shake_din_valid && !shake_din_ready |=> shake_din_valid && $stable(shake_din)
    ) else $error("shake_din withdrawn or changed under back-pressure");

    writes_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(s_wr_en && alpha_wr_en)
    ) else $error("s and alpha write enables high together");

    done_pulse: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else $error("done longer than one cycle");

endmodule

bind support_gen_top support_gen_properties i_support_gen_properties (
    .clk             (clk),
    .rst             (rst),
    .shake_din_valid (shake_din_valid),
    .shake_din       (shake_din),
    .shake_din_ready (shake_din_ready),
    .s_wr_en         (s_wr_en),
    .alpha_wr_en     (alpha_wr_en),
    .done            (done)
);

// ==== support_gen_top.sv ====
`timescale 1ns/10ps

module support_gen_top #(
    parameter mce_pkg::param_set_e PARAM_SET = mce_pkg::param_set_1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             delta_valid,
    input  mce_pkg::word_t                   delta,
    output logic                             delta_ready,
    output logic                             shake_din_valid,
    output mce_pkg::word_t                   shake_din,
    input  logic                             shake_din_ready,
    input  logic                             shake_dout_valid,
    input  mce_pkg::word_t                   shake_dout,
    output logic                             shake_dout_ready,
    output logic                             s_wr_en,
    output logic [7:0]                       s_wr_addr,
    output mce_pkg::word_t                   s_data,
    output logic                             alpha_wr_en,
    output logic [mce_pkg::ALPHA_ADDR_W-1:0] alpha_wr_addr,
    output mce_pkg::word_t                   alpha_data,
    output logic                             done
);

    seed_if seed_bus ();

    logic seed_ready;
    logic msg_sent;

    seed_loader i_seed_loader (
        .clk         (clk),
        .rst         (rst),
        .delta_valid (delta_valid),
        .delta       (delta),
        .delta_ready (delta_ready),
        .run_done    (done),
        .seed_ready  (seed_ready),
        .seed        (seed_bus.loader)
    );

    seed_store i_seed_store (
        .clk  (clk),
        .seed (seed_bus.store)
    );

    shake_feeder #(.PARAM_SET(PARAM_SET)) i_shake_feeder (
        .clk             (clk),
        .rst             (rst),
        .seed_ready      (seed_ready),
        .seed            (seed_bus.feeder),
        .shake_din_valid (shake_din_valid),
        .shake_din       (shake_din),
        .shake_din_ready (shake_din_ready),
        .msg_sent        (msg_sent)
    );

    support_collector #(.PARAM_SET(PARAM_SET)) i_support_collector (
        .clk              (clk),
        .rst              (rst),
        .msg_sent         (msg_sent),
        .shake_dout_valid (shake_dout_valid),
        .shake_dout       (shake_dout),
        .shake_dout_ready (shake_dout_ready),
        .s_wr_en          (s_wr_en),
        .s_wr_addr        (s_wr_addr),
        .s_data           (s_data),
        .alpha_wr_en      (alpha_wr_en),
        .alpha_wr_addr    (alpha_wr_addr),
        .alpha_data       (alpha_data),
        .done             (done)
    );

endmodule

// ==== support_collector.sv ====
`timescale 1ns/10ps

module support_collector #(
    parameter mce_pkg::param_set_e PARAM_SET = mce_pkg::param_set_1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             msg_sent,
    input  logic                             shake_dout_valid,
    input  mce_pkg::word_t                   shake_dout,
    output logic                             shake_dout_ready,
    output logic                             s_wr_en,
    output logic [7:0]                       s_wr_addr,
    output mce_pkg::word_t                   s_data,
    output logic                             alpha_wr_en,
    output logic [mce_pkg::ALPHA_ADDR_W-1:0] alpha_wr_addr,
    output mce_pkg::word_t                   alpha_data,
    output logic                             done
);
    import mce_pkg::*;

    localparam int S_WORDS     = s_words_of(PARAM_SET);
    localparam int ALPHA_WORDS = alpha_words_of(PARAM_SET);

    collector_state_e        state;
    logic [ALPHA_ADDR_W-1:0] word_cnt;
    logic                    accept;

    assign shake_dout_ready = (state == cl_fill_s) || (state == cl_fill_alpha);
    assign accept           = shake_dout_valid && shake_dout_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= cl_idle;
            word_cnt    <= '0;
            s_wr_en     <= 1'b0;
            alpha_wr_en <= 1'b0;
            done        <= 1'b0;
        end else begin
            s_wr_en     <= accept && (state == cl_fill_s);
            alpha_wr_en <= accept && (state == cl_fill_alpha);
            done        <= 1'b0;
            case (state)
                cl_idle: begin
                    word_cnt <= '0;
                    if (msg_sent) begin
                        state <= cl_fill_s;
                    end
                end
                cl_fill_s: begin
                    if (accept) begin
                        if (word_cnt == ALPHA_ADDR_W'(S_WORDS - 1)) begin
                            word_cnt <= '0;
                            state    <= cl_fill_alpha;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                cl_fill_alpha: begin
                    if (accept) begin
                        if (word_cnt == ALPHA_ADDR_W'(ALPHA_WORDS - 1)) begin
                            word_cnt <= '0;
                            state    <= cl_finish;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                cl_finish: begin
                    // last alpha write is on the port this cycle
                    done  <= 1'b1;
                    state <= cl_idle;
                end
                default: state <= cl_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == cl_fill_s) begin
            s_wr_addr <= word_cnt[7:0];
            s_data    <= shake_dout;
        end
        if (accept && state == cl_fill_alpha) begin
            alpha_wr_addr <= word_cnt;
            // field ordering expects the random word msb-first
            alpha_data    <= rev_word(shake_dout);
        end
    end

endmodule

// ==== shake_feeder.sv ====
`timescale 1ns/10ps

module shake_feeder #(
    parameter mce_pkg::param_set_e PARAM_SET = mce_pkg::param_set_1
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           seed_ready,
    seed_if.feeder         seed,
    output logic           shake_din_valid,
    output mce_pkg::word_t shake_din,
    input  logic           shake_din_ready,
    output logic           msg_sent
);
    import mce_pkg::*;

    feeder_state_e state;
    shake_word_e   op;
    seed_addr_t    rd_idx;
    // top byte of the previous stored word, carried into the next word
    logic [7:0]    top_byte;

    assign seed.rd_addr = rd_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= fd_idle;
            op              <= sw_fblock;
            rd_idx          <= '0;
            shake_din_valid <= 1'b0;
            msg_sent        <= 1'b0;
        end else begin
            msg_sent <= 1'b0;
            case (state)
                fd_idle: begin
                    if (seed_ready) begin
                        shake_din_valid <= 1'b1;
                        op              <= sw_fblock;
                        rd_idx          <= '0;
                        state           <= fd_send;
                    end
                end
                fd_send: begin
                    if (shake_din_ready) begin
                        case (op)
                            sw_fblock: begin
                                op <= sw_length;
                            end
                            sw_length: begin
                                // stored word 0 is already on rd_data
                                op     <= sw_seed_first;
                                rd_idx <= seed_addr_t'(1);
                            end
                            sw_seed_tail: begin
                                shake_din_valid <= 1'b0;
                                msg_sent        <= 1'b1;
                                state           <= fd_idle;
                            end
                            default: begin
                                // one bubble while the prefetched word settles
                                shake_din_valid <= 1'b0;
                                state           <= fd_fetch;
                            end
                        endcase
                    end
                end
                fd_fetch: begin
                    shake_din_valid <= 1'b1;
                    state           <= fd_send;
                    // index wrapped to zero once all eight words went out
                    if (rd_idx == '0) begin
                        op <= sw_seed_tail;
                    end else begin
                        op     <= sw_seed_mid;
                        rd_idx <= rd_idx + 1'b1;
                    end
                end
                default: state <= fd_idle;
            endcase
        end
    end

    // message word and carried byte, loaded alongside the control above
    always_ff @(posedge clk) begin
        if (state == fd_idle && seed_ready) begin
            shake_din <= fblock_of(PARAM_SET);
        end else if (state == fd_send && shake_din_ready && op == sw_fblock) begin
            shake_din <= SHAKE_LEN_WORD;
        end else if (state == fd_send && shake_din_ready && op == sw_length) begin
            shake_din <= {seed.rd_data[23:0], 8'h40};
            top_byte  <= seed.rd_data[31:24];
        end else if (state == fd_fetch) begin
            if (rd_idx == '0) begin
                shake_din <= {24'h000000, top_byte};
            end else begin
                shake_din <= {seed.rd_data[23:0], top_byte};
                top_byte  <= seed.rd_data[31:24];
            end
        end
    end

endmodule

// ==== seed_store.sv ====
`timescale 1ns/10ps

module seed_store (
    input logic   clk,
    seed_if.store seed
);
    import mce_pkg::*;

    word_t mem [SEED_WORDS];

    always_ff @(posedge clk) begin
        if (seed.wr_en) begin
            mem[seed.wr_addr] <= seed.wr_data;
        end
    end

    // registered read port for the feeder
    always_ff @(posedge clk) begin
        seed.rd_data <= mem[seed.rd_addr];
    end

endmodule

// ==== seed_loader.sv ====
`timescale 1ns/10ps

module seed_loader (
    input  logic           clk,
    input  logic           rst,
    input  logic           delta_valid,
    input  mce_pkg::word_t delta,
    output logic           delta_ready,
    input  logic           run_done,
    output logic           seed_ready,
    seed_if.loader         seed
);
    import mce_pkg::*;

    loader_state_e state;
    seed_addr_t    word_cnt;
    logic          accept;

    assign delta_ready = (state == ld_idle);
    assign accept      = delta_valid && delta_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ld_idle;
            word_cnt   <= '0;
            seed.wr_en <= 1'b0;
            seed_ready <= 1'b0;
        end else begin
            seed.wr_en <= accept;
            // eighth word is in the store now
            seed_ready <= seed.wr_en && (seed.wr_addr == seed_addr_t'(SEED_WORDS - 1));
            case (state)
                ld_idle: begin
                    if (accept) begin
                        // wraps back to zero after the last word
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == seed_addr_t'(SEED_WORDS - 1)) begin
                            state <= ld_busy;
                        end
                    end
                end
                ld_busy: begin
                    // hold off new seeds until the run completes
                    if (run_done) begin
                        state <= ld_idle;
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // delta word stored bit-reversed
    always_ff @(posedge clk) begin
        if (accept) begin
            seed.wr_addr <= word_cnt;
            seed.wr_data <= rev_word(delta);
        end
    end

endmodule

// ==== seed_if.sv ====
`timescale 1ns/10ps

interface seed_if;
    import mce_pkg::*;

    logic       wr_en;
    seed_addr_t wr_addr;
    word_t      wr_data;
    seed_addr_t rd_addr;
    word_t      rd_data;

    // write side
    modport loader (output wr_en, output wr_addr, output wr_data);

    // read side, data one cycle after address
    modport feeder (output rd_addr, input rd_data);

    modport store (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

// ==== mce_pkg.sv ====
package mce_pkg;

    // one bus word for delta, SHAKE and s data
    typedef logic [31:0] word_t;

    localparam int SEED_WORDS = 8;
    typedef logic [2:0] seed_addr_t;

    // alpha address sized for the largest field, M = 13
    localparam int ALPHA_ADDR_W = 13;

    typedef enum logic [2:0] {
        param_set_1 = 3'd1,
        param_set_2 = 3'd2,
        param_set_3 = 3'd3,
        param_set_5 = 3'd5
    } param_set_e;

    // SHAKE input length word, fixed for a 256-bit seed
    localparam word_t SHAKE_LEN_WORD = 32'h80000108;

    typedef enum logic [0:0] {ld_idle, ld_busy} loader_state_e;
    typedef enum logic [1:0] {fd_idle, fd_send, fd_fetch} feeder_state_e;
    typedef enum logic [1:0] {cl_idle, cl_fill_s, cl_fill_alpha, cl_finish} collector_state_e;

    // which message word the feeder is offering
    typedef enum logic [2:0] {
        sw_fblock,
        sw_length,
        sw_seed_first,
        sw_seed_mid,
        sw_seed_tail
    } shake_word_e;

    function automatic int m_of(param_set_e ps);
        return (ps == param_set_1) ? 12 : 13;
    endfunction

    // N / 32
    function automatic int s_words_of(param_set_e ps);
        case (ps)
            param_set_1: return 109;
            param_set_2: return 144;
            param_set_3: return 209;
            default:     return 256;
        endcase
    endfunction

    // one 32-bit random word per field element
    function automatic int alpha_words_of(param_set_e ps);
        return 1 << m_of(ps);
    endfunction

    function automatic word_t fblock_of(param_set_e ps);
        case (ps)
            param_set_1: return 32'h40020DA0;
            param_set_2: return 32'h40041200;
            param_set_3: return 32'h40041A20;
            default:     return 32'h40042000;
        endcase
    endfunction

    function automatic word_t rev_word(word_t w);
        word_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = w[31-i];
        end
        return r;
    endfunction

endpackage
